/* compile.f */
+incdir+design
+incdir+verif
design/trs_io_pkg.sv
design/bus_decoder.sv
design/esp_wait_ctrl.sv
design/spi_slave.sv
design/cmd_parser.sv
design/sound_out.sv
design/trs_io_top.sv
verif/tb_trs_io.sv

/* verif/tb_trs_io_tests.svh */
// expected ones per 512 cycles as the offset binary sample
function automatic int pdm_density(input byte_t orch, input logic [1:0] cass);
  int lvl;
  lvl = (cass[1] ? 0 : 1) + (cass[0] ? 1 : 0);
  return int'($signed(orch)) + (lvl - 1) * 128 + 256;
endfunction

task automatic port_write(input io_addr_t a, input byte_t data);
  bus_out(a, data);
  wait_cycles(6);
  bus_release();
endtask

// one esp-handled cycle with its wait and request timing
task automatic esp_cycle(input string name, input logic is_in, input io_addr_t port,
                         input esp_code_t code, input byte_t data);
  int n;
  int lat;
  if (is_in)
    bus_in(port);
  else
    bus_out(port, data);
  wait_cycles(1);
  check_value({name, "/esp_s"}, code, esp_s);
  check_value({name, "/extiosel"}, is_in, extiosel);
  check_value({name, "/dbus_dir"}, !is_in, dbus_dir);   // low points toward the cpu
  if (is_in) begin
    check_value({name, "/d"}, data, d);
    check_value({name, "/dbus_en"}, 0, dbus_en);
  end
  n = 0;
  while (!esp_req && n < 20) begin
    wait_cycles(1);
    n++;
  end
  check_value({name, "/wait_o with esp_req"}, 1, wait_o);
  check_value({name, "/led wait and busy"}, 2'b11, led[1:0]);
  n = 0;
  while (esp_req && n < 100) begin
    wait_cycles(1);
    n++;
  end
  check_value({name, "/esp_req length"}, `ESP_REQ_CYCLES, n);
  pulse_esp_done(lat);
  check_range({name, "/wait_o release"}, 1, 6, lat);
  bus_release();
endtask

task automatic reset_values();
  int e0;
  e0 = errors;
  check_value("reset_values/wait_o", 0, wait_o);
  check_value("reset_values/esp_req", 0, esp_req);
  check_value("reset_values/int_o", 0, int_o);
  check_value("reset_values/extiosel", 0, extiosel);
  check_value("reset_values/dbus_dir", 1, dbus_dir);
  check_value("reset_values/dbus_en", 1, dbus_en);
  check_value("reset_values/led", 0, led);
  check_value("reset_values/rgb", 0, {led_blue, led_green, led_red});
  check_value("reset_values/esp_s", `ESP_IDLE, esp_s);
  check_value("reset_values/miso", 1'bz, miso);
  check_value("reset_values/pdm", 0, {cass_out_l, cass_out_r});
  report_test("reset_values", e0);
endtask

task automatic identity();
  int e0;
  byte_t rx;
  e0 = errors;
  spi_xfer(`OP_GET_COOKIE, rx);
  spi_xfer(`OP_GET_VERSION, rx);
  check_value("identity/cookie", `COOKIE, rx);
  spi_xfer(`OP_GET_COOKIE, rx);   // dummy that brings the version back
  check_value("identity/version", `VERSION_BYTE, rx);
  report_test("identity", e0);
endtask

task automatic esp_in_out();
  int e0;
  byte_t rx;
  byte_t val;
  e0 = errors;
  val = byte_t'($urandom);
  spi_xfer(`OP_DBUS_WRITE, rx);
  spi_xfer(val, rx);
  esp_cycle("esp_in_out/trs_io in", 1'b1, `TRS_IO_PORT, `ESP_TRS_IO_IN, val);
  esp_cycle("esp_in_out/frehd out", 1'b0, `FREHD_BASE | io_addr_t'($urandom & 'hF),
            `ESP_FREHD_OUT, byte_t'($urandom));
  esp_cycle("esp_in_out/printer wr", 1'b0, `PRINTER_BASE | io_addr_t'($urandom & 'h3),
            `ESP_PRINTER_WR, byte_t'($urandom));
  report_test("esp_in_out", e0);
endtask

task automatic bus_capture();
  int e0;
  byte_t rx;
  byte_t val;
  io_addr_t adr;
  e0 = errors;
  val = byte_t'($urandom);
  adr = io_addr_t'($urandom);
  addr = adr;   // no strobes so nothing is selected
  d_drv = val;
  d_drv_en = 1'b1;
  spi_xfer(`OP_DBUS_READ, rx);
  spi_xfer(`OP_ABUS_READ, rx);
  check_value("bus_capture/data", val, rx);
  spi_xfer(`OP_GET_COOKIE, rx);
  check_value("bus_capture/addr", adr, rx);
  d_drv_en = 1'b0;
  report_test("bus_capture", e0);
endtask

task automatic control_regs();
  int e0;
  int n;
  byte_t rx;
  byte_t val;
  e0 = errors;
  val = byte_t'($urandom);
  repeat (2) begin
    spi_xfer(`OP_SET_LED, rx);
    spi_xfer(val, rx);
    check_value("control_regs/rgb", val[2:0], {led_blue, led_green, led_red});
    spi_xfer(`OP_SET_ESP_STATUS, rx);
    spi_xfer(val, rx);
    check_value("control_regs/led3", val[0], led[3]);
    val = ~val;   // every bit at both levels
  end
  conf = 4'($urandom);
  spi_xfer(`OP_GET_CONFIG, rx);
  spi_xfer(`OP_GET_COOKIE, rx);
  check_value("control_regs/config", 8'h0F ^ {4'h0, conf}, rx);
  spi_xfer(`OP_DATA_READY, rx);
  check_value("control_regs/int set", 1, int_o);
  bus_in(`TRS_IO_PORT);
  n = 0;
  while (int_o && n < 10) begin
    wait_cycles(1);
    n++;
  end
  check_value("control_regs/int clear", 0, int_o);
  pulse_esp_done(n);
  bus_release();
  report_test("control_regs", e0);
endtask

task automatic sound_levels();
  int e0;
  int ones_l;
  int ones_r;
  byte_t orch_l;
  byte_t orch_r;
  logic [1:0] cass;
  e0 = errors;
  orch_l = byte_t'($urandom);
  orch_r = byte_t'($urandom);
  cass = 2'($urandom);
  port_write(`CASS_PORT, {6'b0, cass});
  port_write(`ORCH_L_PORT, orch_l);
  port_write(`ORCH_R_PORT, orch_r);
  wait_cycles(4);   // sample registers settle
  ones_l = 0;
  ones_r = 0;
  repeat (5120) begin
    wait_cycles(1);
    ones_l += cass_out_l;
    ones_r += cass_out_r;
  end
  check_range("sound_levels/left", pdm_density(orch_l, cass) - 2,
              pdm_density(orch_l, cass) + 2, ones_l / 10);
  check_range("sound_levels/right", pdm_density(orch_r, cass) - 2,
              pdm_density(orch_r, cass) + 2, ones_r / 10);
  report_test("sound_levels", e0);
endtask

task automatic error_flag();
  int e0;
  byte_t rx;
  e0 = errors;
  check_value("error_flag/clear before", 0, led[2]);
  spi_xfer(8'h7F, rx);   // not an opcode
  check_value("error_flag/set", 1, led[2]);
  spi_xfer(`OP_GET_COOKIE, rx);
  spi_xfer(`OP_GET_VERSION, rx);
  check_value("error_flag/cookie after error", `COOKIE, rx);
  check_value("error_flag/held", 1, led[2]);
  report_test("error_flag", e0);
endtask

/* verif/tb_trs_io.sv */
`timescale 1ns/1ns
`include "trs_io_cfg.svh"

module tb_trs_io;
  import trs_io_pkg::*;

  localparam int timeout_cycles = 20000;   // about twice the summed test length

  logic       clk;
  logic       reset;
  logic       in_n;
  logic       out_n;
  logic       ioreq_n;
  io_addr_t   addr;
  wire  [7:0] d;
  byte_t      d_drv;
  logic       d_drv_en;
  logic       cs_n;
  logic       sck;
  logic       mosi;
  wire        miso;
  logic       esp_done;
  logic [3:0] conf;
  esp_code_t  esp_s;
  logic       esp_req;
  logic       wait_o;
  logic       int_o;
  logic       extiosel;
  logic       dbus_dir;
  logic       dbus_en;
  logic [3:0] led;
  logic       led_red;
  logic       led_green;
  logic       led_blue;
  logic       cass_out_l;
  logic       cass_out_r;

  int errors = 0;
  int checks = 0;
  int tests_run = 0;
  int cycles = 0;

  assign d = d_drv_en ? d_drv : 'z;   // cpu side of the data bus

  trs_io_top i_trs_io_top (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp)
    else begin
      $display("Fail %s: expected %0h, actual %0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_range(input string name, input int lo, input int hi, input int act);
    checks++;
    assert (act >= lo && act <= hi)
    else begin
      $display("Fail %s: expected %0d to %0d, actual %0d", name, lo, hi, act);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before)
      $display("%s done, no errors", name);
    else
      $display("%s done, %0d errors", name, errors - errors_before);
  endtask

  task automatic bus_in(input io_addr_t a);
    addr     = a;
    d_drv_en = 1'b0;   // the fpga answers on d
    in_n     = 1'b0;
    ioreq_n  = 1'b0;
  endtask

  task automatic bus_out(input io_addr_t a, input byte_t data);
    addr     = a;
    d_drv    = data;
    d_drv_en = 1'b1;
    out_n    = 1'b0;
    ioreq_n  = 1'b0;
  endtask

  task automatic bus_release();
    in_n     = 1'b1;
    out_n    = 1'b1;
    ioreq_n  = 1'b1;
    d_drv_en = 1'b0;
    wait_cycles(4);   // strobe synchroniser drains
  endtask

  // holds esp_done high until wait_o drops and returns the latency in cycles
  task automatic pulse_esp_done(output int lat);
    esp_done = 1'b1;
    lat = 0;
    while (wait_o && lat < 20) begin
      wait_cycles(1);
      lat++;
    end
    esp_done = 1'b0;
    wait_cycles(4);
  endtask

  // mode 0 msb first at clk/16 with miso read just before each rising edge
  task automatic spi_xfer(input byte_t tx, output byte_t rx);
    cs_n = 1'b0;
    for (int i = 0; i < 8; i++) begin
      mosi = tx[7 - i];
      wait_cycles(8);
      if (i > 0)
        rx[8 - i] = miso;
      sck = 1'b1;
      wait_cycles(8);
      sck = 1'b0;
    end
    wait_cycles(8);
    rx[0] = miso;   // last bit shows after the eighth falling edge
    cs_n = 1'b1;
    wait_cycles(4);
  endtask

  `include "tb_trs_io_tests.svh"

  initial begin
    void'($urandom(49979));
    reset    = 1'b1;
    in_n     = 1'b1;
    out_n    = 1'b1;
    ioreq_n  = 1'b1;
    addr     = '0;
    d_drv    = '0;
    d_drv_en = 1'b0;
    cs_n     = 1'b1;
    sck      = 1'b0;
    mosi     = 1'b0;
    esp_done = 1'b0;
    conf     = 4'hF;
    wait_cycles(8);
    reset_values();   // still in reset here
    reset = 1'b0;
    wait_cycles(4);
    identity();
    esp_in_out();
    bus_capture();
    control_regs();
    sound_levels();
    error_flag();
    $display("tests: %0d, checks: %0d, failures: %0d", tests_run, checks, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* design/trs_io_top.sv */
`timescale 1ns/1ns

module trs_io_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_n,
  input  logic                  out_n,
  input  logic                  ioreq_n,
  input  trs_io_pkg::io_addr_t  addr,
  inout  wire [7:0]             d,
  input  logic                  cs_n,
  input  logic                  sck,
  input  logic                  mosi,
  output wire                   miso,
  input  logic                  esp_done,
  input  logic [3:0]            conf,
  output trs_io_pkg::esp_code_t esp_s,
  output logic                  esp_req,
  output logic                  wait_o,
  output logic                  int_o,
  output logic                  extiosel,
  output logic                  dbus_dir,
  output logic                  dbus_en,
  output logic [3:0]            led,
  output logic                  led_red,
  output logic                  led_green,
  output logic                  led_blue,
  output logic                  cass_out_l,
  output logic                  cass_out_r
);
  import trs_io_pkg::*;

  bus_access_t access;
  io_sel_t     sel;
  byte_t       trs_data;
  byte_t       d_out;
  logic        d_oe;
  logic        esp_busy;
  logic        byte_rx;
  byte_t       rx_byte;
  byte_t       tx_byte;
  logic        miso_data;
  logic        miso_oe;
  byte_t       esp_status;
  logic [2:0]  rgb_led;
  logic        cmd_error;

  bus_decoder i_bus_decoder (
    .clk      (clk),
    .reset    (reset),
    .in_n     (in_n),
    .out_n    (out_n),
    .ioreq_n  (ioreq_n),
    .addr     (addr),
    .d_in     (d),
    .trs_data (trs_data),
    .access   (access),
    .sel      (sel),
    .esp_s    (esp_s),
    .extiosel (extiosel),
    .dbus_dir (dbus_dir),
    .dbus_en  (dbus_en),
    .d_out    (d_out),
    .d_oe     (d_oe)
  );

  esp_wait_ctrl i_esp_wait_ctrl (
    .clk      (clk),
    .reset    (reset),
    .access   (access),
    .sel      (sel),
    .esp_done (esp_done),
    .wait_o   (wait_o),
    .esp_req  (esp_req),
    .esp_busy (esp_busy)
  );

  spi_slave i_spi_slave (
    .clk       (clk),
    .reset     (reset),
    .cs_n      (cs_n),
    .sck       (sck),
    .mosi      (mosi),
    .tx_byte   (tx_byte),
    .byte_rx   (byte_rx),
    .rx_byte   (rx_byte),
    .miso_data (miso_data),
    .miso_oe   (miso_oe)
  );

  cmd_parser i_cmd_parser (
    .clk        (clk),
    .reset      (reset),
    .byte_rx    (byte_rx),
    .rx_byte    (rx_byte),
    .access     (access),
    .sel        (sel),
    .d_in       (d),
    .addr       (addr),
    .conf       (conf),
    .tx_byte    (tx_byte),
    .trs_data   (trs_data),
    .int_o      (int_o),
    .esp_status (esp_status),
    .rgb_led    (rgb_led),
    .cmd_error  (cmd_error)
  );

  sound_out i_sound_out (
    .clk        (clk),
    .reset      (reset),
    .access     (access),
    .sel        (sel),
    .cass_out_l (cass_out_l),
    .cass_out_r (cass_out_r)
  );

  // tri-state pins
  assign d    = d_oe ? d_out : 'z;
  assign miso = miso_oe ? miso_data : 1'bz;   // released while cs_n is high

  // led[3] is the esp ready bit
  assign led       = {esp_status[0], cmd_error, esp_busy, wait_o};
  assign led_red   = rgb_led[0];
  assign led_green = rgb_led[1];
  assign led_blue  = rgb_led[2];

endmodule

/* design/sound_out.sv */
`timescale 1ns/1ns

module sound_out (
  input  logic                    clk,
  input  logic                    reset,
  input  trs_io_pkg::bus_access_t access,
  input  trs_io_pkg::io_sel_t     sel,
  output logic                    cass_out_l,
  output logic                    cass_out_r
);
  import trs_io_pkg::*;

  byte_t      orch_l;
  byte_t      orch_r;
  logic [1:0] cass;
  logic [1:0] cass_lvl;   // 0, 1 or 2
  logic [8:0] sample_l;
  logic [8:0] sample_r;
  logic [9:0] pdm_l;      // bit 9 is the carry out
  logic [9:0] pdm_r;

  // signed orchestra byte plus cassette level centred on 1
  function automatic logic [8:0] mix(input byte_t orch, input logic [1:0] lvl);
    logic [1:0] ofs;
    ofs = lvl - 2'd1;
    return {orch[7], orch} + {ofs, 7'b0};
  endfunction

  assign cass_lvl = {1'b0, ~cass[1]} + {1'b0, cass[0]};

  always_ff @(posedge clk) begin
    if (reset) begin
      orch_l   <= '0;
      orch_r   <= '0;
      cass     <= '0;
      sample_l <= '0;
      sample_r <= '0;
      pdm_l    <= '0;
      pdm_r    <= '0;
    end else begin
      if (access.strobe && sel.orch_l_out)
        orch_l <= access.data;
      if (access.strobe && sel.orch_r_out)
        orch_r <= access.data;
      if (access.strobe && sel.cass_out)
        cass <= access.data[1:0];
      sample_l <= mix(orch_l, cass_lvl);
      sample_r <= mix(orch_r, cass_lvl);
      // first order pdm on offset binary
      pdm_l <= {1'b0, pdm_l[8:0]} + {1'b0, ~sample_l[8], sample_l[7:0]};
      pdm_r <= {1'b0, pdm_r[8:0]} + {1'b0, ~sample_r[8], sample_r[7:0]};
    end
  end

  assign cass_out_l = pdm_l[9];
  assign cass_out_r = pdm_r[9];

endmodule

/* design/cmd_parser.sv */
`timescale 1ns/1ns
`include "trs_io_cfg.svh"

module cmd_parser (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    byte_rx,
  input  trs_io_pkg::byte_t       rx_byte,
  input  trs_io_pkg::bus_access_t access,
  input  trs_io_pkg::io_sel_t     sel,
  input  trs_io_pkg::byte_t       d_in,
  input  trs_io_pkg::io_addr_t    addr,
  input  logic [3:0]              conf,
  output trs_io_pkg::byte_t       tx_byte,
  output trs_io_pkg::byte_t       trs_data,
  output logic                    int_o,
  output trs_io_pkg::byte_t       esp_status,
  output logic [2:0]              rgb_led,
  output logic                    cmd_error
);
  import trs_io_pkg::*;

  parser_state_t state;
  byte_t         opcode_q;   // opcode waiting for its parameter
  cmd_action_t   action;
  logic          trs_io_access;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle;
      action    <= '0;
      cmd_error <= 1'b0;
    end else begin
      action.trigger <= 1'b0;
      if (byte_rx) begin
        case (state)
          idle: begin
            case (rx_byte)
              `OP_GET_COOKIE, `OP_GET_VERSION, `OP_DBUS_READ, `OP_ABUS_READ,
              `OP_DATA_READY, `OP_GET_CONFIG: begin
                action <= '{trigger: 1'b1, opcode: rx_byte, param: '0};
              end
              `OP_DBUS_WRITE, `OP_SET_LED, `OP_SET_ESP_STATUS: begin
                state <= read_bytes;
              end
              default: begin
                cmd_error <= 1'b1;   // sticky until reset
              end
            endcase
          end
          read_bytes: begin
            action <= '{trigger: 1'b1, opcode: opcode_q, param: rx_byte};
            state  <= idle;
          end
          default: begin
            state <= idle;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (byte_rx && state == idle)
      opcode_q <= rx_byte;
  end

  // response goes out in the next transfer
  always_ff @(posedge clk) begin
    if (action.trigger) begin
      case (action.opcode)
        `OP_GET_COOKIE:  tx_byte <= `COOKIE;
        `OP_GET_VERSION: tx_byte <= `VERSION_BYTE;
        `OP_DBUS_READ:   tx_byte <= d_in;
        `OP_ABUS_READ:   tx_byte <= addr;
        `OP_GET_CONFIG:  tx_byte <= {4'h0, ~conf};   // dip switches are active low
        default: ;
      endcase
      if (action.opcode == `OP_DBUS_WRITE)
        trs_data <= action.param;   // served on the next ESP IN cycle
    end
  end

  assign trs_io_access = access.strobe & (sel.trs_io_in | sel.trs_io_out);

  always_ff @(posedge clk) begin
    if (reset) begin
      esp_status <= '0;
      rgb_led    <= '0;
      int_o      <= 1'b0;
    end else begin
      if (action.trigger && action.opcode == `OP_SET_ESP_STATUS)
        esp_status <= action.param;
      if (action.trigger && action.opcode == `OP_SET_LED)
        rgb_led <= action.param[2:0];
      if (action.trigger && action.opcode == `OP_DATA_READY)
        int_o <= 1'b1;
      else if (trs_io_access)
        int_o <= 1'b0;   // cpu touched trs-io so the interrupt was seen
    end
  end

endmodule

/* design/spi_slave.sv */
`timescale 1ns/1ns

module spi_slave (
  input  logic              clk,
  input  logic              reset,
  input  logic              cs_n,
  input  logic              sck,
  input  logic              mosi,
  input  trs_io_pkg::byte_t tx_byte,
  output logic              byte_rx,
  output trs_io_pkg::byte_t rx_byte,
  output logic              miso_data,
  output logic              miso_oe
);
  import trs_io_pkg::*;

  logic [2:0] sck_sync;
  logic       sck_q;
  logic [2:0] mosi_sync;  // same depth as sck so the bit lines up
  logic [1:0] cs_sync;
  logic       cs_active;
  logic       sck_rise;
  logic       sck_fall;
  logic [2:0] bit_cnt;
  byte_t      rx_sr;
  byte_t      tx_sr;

  assign sck_rise  = sck_sync[2] & ~sck_q;
  assign sck_fall  = ~sck_sync[2] & sck_q;
  assign cs_active = ~cs_sync[1];

  always_ff @(posedge clk) begin
    if (reset) begin
      sck_sync <= '0;
      sck_q    <= 1'b0;
      cs_sync  <= 2'b11;
      bit_cnt  <= '0;
      byte_rx  <= 1'b0;
    end else begin
      sck_sync <= {sck_sync[1:0], sck};
      sck_q    <= sck_sync[2];
      cs_sync  <= {cs_sync[0], cs_n};
      byte_rx  <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        byte_rx <= (bit_cnt == 3'd7);   // eighth bit in
      end
    end
  end

  always_ff @(posedge clk) begin
    mosi_sync <= {mosi_sync[1:0], mosi};
    if (cs_active && sck_rise)
      rx_sr <= {rx_sr[6:0], mosi_sync[2]};   // msb first
    if (cs_active && sck_fall) begin
      if (bit_cnt == 3'd1)
        tx_sr <= tx_byte;   // first falling edge of the byte
      else
        tx_sr <= {tx_sr[6:0], 1'b0};
    end
  end

  assign rx_byte   = rx_sr;
  assign miso_data = tx_sr[7];
  assign miso_oe   = cs_active;

endmodule

/* design/esp_wait_ctrl.sv */
`timescale 1ns/1ns
`include "trs_io_cfg.svh"

module esp_wait_ctrl (
  input  logic                    clk,
  input  logic                    reset,
  input  trs_io_pkg::bus_access_t access,
  input  trs_io_pkg::io_sel_t     sel,
  input  logic                    esp_done,
  output logic                    wait_o,
  output logic                    esp_req,
  output logic                    esp_busy
);

  logic       esp_sel;
  logic       esp_start;
  logic [2:0] done_sync;
  logic       done_q;
  logic       done_rise;
  logic [5:0] req_cnt;    // cycles left of esp_req

  assign esp_sel = sel.trs_io_in | sel.trs_io_out | sel.frehd_in |
                   sel.frehd_out | sel.printer_rd | sel.printer_wr;

  assign esp_busy  = esp_sel;
  assign esp_start = access.strobe & esp_sel;
  assign done_rise = done_sync[2] & ~done_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      done_sync <= '0;
      done_q    <= 1'b0;
      req_cnt   <= '0;
      wait_o    <= 1'b0;
    end else begin
      done_sync <= {done_sync[1:0], esp_done};
      done_q    <= done_sync[2];
      if (esp_start) begin
        // new access restarts the request and holds the cpu
        req_cnt <= 6'(`ESP_REQ_CYCLES);
        wait_o  <= 1'b1;
      end else begin
        if (req_cnt != '0)
          req_cnt <= req_cnt - 6'd1;
        if (done_rise)
          wait_o <= 1'b0;   // esp finished so the cpu goes on
      end
    end
  end

  assign esp_req = (req_cnt != '0);

endmodule

/* design/bus_decoder.sv */
`timescale 1ns/1ns
`include "trs_io_cfg.svh"

module bus_decoder (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    in_n,
  input  logic                    out_n,
  input  logic                    ioreq_n,
  input  trs_io_pkg::io_addr_t    addr,
  input  trs_io_pkg::byte_t       d_in,
  input  trs_io_pkg::byte_t       trs_data,
  output trs_io_pkg::bus_access_t access,
  output trs_io_pkg::io_sel_t     sel,
  output trs_io_pkg::esp_code_t   esp_s,
  output logic                    extiosel,
  output logic                    dbus_dir,
  output logic                    dbus_en,
  output trs_io_pkg::byte_t       d_out,
  output logic                    d_oe
);
  import trs_io_pkg::*;

  logic       in_act;
  logic       out_act;
  logic       trs_io_hit;
  logic       frehd_hit;
  logic       printer_hit;
  logic       esp_sel_in;
  logic [2:0] act_sync;   // two sync flops and the edge flop
  logic       act_rise;
  logic       strobe_q;
  io_addr_t   addr_s1;
  io_addr_t   addr_s2;
  io_addr_t   addr_q;
  byte_t      data_q;

  assign in_act  = ~in_n & ~ioreq_n;
  assign out_act = ~out_n & ~ioreq_n;
  assign act_rise = act_sync[1] & ~act_sync[2];

  always_ff @(posedge clk) begin
    if (reset) begin
      act_sync <= '0;
      strobe_q <= 1'b0;
    end else begin
      act_sync <= {act_sync[1:0], in_act | out_act};
      strobe_q <= act_rise;
    end
  end

  // address and data captured together at the access edge
  always_ff @(posedge clk) begin
    addr_s1 <= addr;
    addr_s2 <= addr_s1;
    if (act_rise) begin
      addr_q <= addr_s2;
      data_q <= d_in;
    end
  end

  assign access = '{strobe: strobe_q, addr: addr_q, data: data_q};

  assign trs_io_hit  = (addr == `TRS_IO_PORT);
  assign frehd_hit   = ((addr & 8'hF0) == `FREHD_BASE);
  assign printer_hit = ((addr & 8'hFC) == `PRINTER_BASE);

  always_comb begin
    sel.trs_io_in  = trs_io_hit & in_act;
    sel.trs_io_out = trs_io_hit & out_act;
    sel.frehd_in   = frehd_hit & in_act;
    sel.frehd_out  = frehd_hit & out_act;
    sel.printer_rd = printer_hit & in_act;
    sel.printer_wr = printer_hit & out_act;
    sel.cass_out   = (addr == `CASS_PORT) & out_act;
    sel.orch_l_out = (addr == `ORCH_L_PORT) & out_act;
    sel.orch_r_out = (addr == `ORCH_R_PORT) & out_act;
  end

  always_comb begin
    if (sel.trs_io_in)
      esp_s = `ESP_TRS_IO_IN;
    else if (sel.trs_io_out)
      esp_s = `ESP_TRS_IO_OUT;
    else if (sel.frehd_in)
      esp_s = `ESP_FREHD_IN;
    else if (sel.frehd_out)
      esp_s = `ESP_FREHD_OUT;
    else if (sel.printer_rd)
      esp_s = `ESP_PRINTER_RD;
    else if (sel.printer_wr)
      esp_s = `ESP_PRINTER_WR;
    else
      esp_s = `ESP_IDLE;
  end

  assign esp_sel_in = sel.trs_io_in | sel.frehd_in | sel.printer_rd;

  // the fpga answers ESP-handled reads itself
  assign extiosel = esp_sel_in;
  assign d_oe     = esp_sel_in;
  assign d_out    = trs_data;
  assign dbus_dir = ~in_act;                 // low turns the transceiver toward the cpu
  assign dbus_en  = ~(out_act | esp_sel_in); // active low

endmodule

/* design/trs_io_pkg.sv */
package trs_io_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [7:0] io_addr_t;
  typedef logic [3:0] esp_code_t;

  typedef enum logic {
    idle,
    read_bytes    // waiting for the parameter byte
  } parser_state_t;

  // port selects decoded from the live bus
  typedef struct packed {
    logic trs_io_in;
    logic trs_io_out;
    logic frehd_in;
    logic frehd_out;
    logic printer_rd;
    logic printer_wr;
    logic cass_out;
    logic orch_l_out;
    logic orch_r_out;
  } io_sel_t;

  // synchronised snapshot of one bus access
  typedef struct packed {
    logic     strobe;   // one cycle per access
    io_addr_t addr;
    byte_t    data;
  } bus_access_t;

  typedef struct packed {
    logic  trigger;
    byte_t opcode;
    byte_t param;   // first parameter byte
  } cmd_action_t;

endpackage

/* design/trs_io_cfg.svh */
`ifndef TRS_IO_CFG_SVH
`define TRS_IO_CFG_SVH

// z80 i/o ports
`define TRS_IO_PORT       8'h1F
`define FREHD_BASE        8'hC0   // C0h-CFh
`define PRINTER_BASE      8'hF8   // F8h-FBh
`define CASS_PORT         8'hFF
`define ORCH_L_PORT       8'h75
`define ORCH_R_PORT       8'h79

// command opcodes sent by the esp
`define OP_GET_COOKIE     8'd0
`define OP_DBUS_READ      8'd3
`define OP_DBUS_WRITE     8'd4
`define OP_DATA_READY     8'd5
`define OP_GET_VERSION    8'd15
`define OP_ABUS_READ      8'd18
`define OP_SET_LED        8'd26
`define OP_GET_CONFIG     8'd27
`define OP_SET_ESP_STATUS 8'd32

`define COOKIE            8'hAF
`define VERSION_BYTE      8'h03   // major 0, minor 3

// esp selector codes on esp_s
`define ESP_TRS_IO_IN     4'd0
`define ESP_TRS_IO_OUT    4'd1
`define ESP_FREHD_IN      4'd2
`define ESP_FREHD_OUT     4'd3
`define ESP_PRINTER_RD    4'd4
`define ESP_PRINTER_WR    4'd5
`define ESP_IDLE          4'hF

`define ESP_REQ_CYCLES    50      // esp_req pulse length in clk cycles

`endif
